/* logic/core_config.svh */
// core-wide sizes; RESET_PC must match the base address of the fetch memory image
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// register and datapath width
`define XLEN 64

// first fetch address after reset
`define RESET_PC 64'h0

// architectural integer registers, x0 included
`define NREGS 32

`endif

/* logic/riscv_isa_pkg.sv */
// rv64i subset only; branch funct3 names cover BEQ and BNE, nothing else
package riscv_isa_pkg;

  // supported major opcodes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // BRANCH
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } inst_i_t;

  // one instruction word, register view and I-immediate view
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

endpackage

/* logic/core_pipe_pkg.sv */
// internal pipeline encodings; values are not architectural and may be reordered
package core_pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // source of the value written to rd
  typedef enum logic [1:0] {
    RES_ALU,
    RES_PC4,
    RES_IMM
  } res_sel_e;

endpackage

/* logic/if_stage.sv */
// one wishbone read at a time, no write path; fetch halts after JAL or a branch until redirect
`timescale 1ns/1ps
`include "core_config.svh"

module if_stage
  import riscv_isa_pkg::*;
(
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_fetched_ack,
  input  logic [31:0]      i_wb_dat,
  input  logic             i_wb_ack,
  input  logic             i_redirect,
  input  logic [`XLEN-1:0] i_redirect_pc,
  output logic             o_wb_cyc,
  output logic             o_wb_stb,
  output logic [`XLEN-1:0] o_wb_adr,
  output logic             o_fetched_req,
  output logic [`XLEN-1:0] o_if_pc,
  output logic [31:0]      o_if_inst
);

  logic [`XLEN-1:0] pc;
  logic             cyc;
  logic             wait_resolve;
  logic             fetch_start;
  logic             fetch_done;
  logic             fetch_is_ctrl;

  // output register stays empty for the whole bus cycle
  assign fetch_start = !cyc && !wait_resolve && (!o_fetched_req || i_fetched_ack);
  assign fetch_done  = cyc && i_wb_ack;

  // predecode of the returned word
  assign fetch_is_ctrl = (i_wb_dat[6:0] == OPC_JAL) || (i_wb_dat[6:0] == OPC_BRANCH);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc            <= `RESET_PC;
      cyc           <= 1'b0;
      wait_resolve  <= 1'b0;
      o_fetched_req <= 1'b0;
    end else begin
      if (fetch_start) begin
        cyc <= 1'b1;
      end else if (fetch_done) begin
        cyc          <= 1'b0;
        pc           <= pc + `XLEN'd4;
        wait_resolve <= fetch_is_ctrl;
      end
      // only arrives while waiting, so never during a bus cycle
      if (i_redirect) begin
        pc           <= i_redirect_pc;
        wait_resolve <= 1'b0;
      end
      if (fetch_done) begin
        o_fetched_req <= 1'b1;
      end else if (i_fetched_ack) begin
        o_fetched_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done) begin
      o_if_pc   <= pc;
      o_if_inst <= i_wb_dat;
    end
  end

  assign o_wb_cyc = cyc;
  assign o_wb_stb = cyc;
  assign o_wb_adr = pc;

  // classic cycle keeps stb and address until the slave acks
  a_stb_until_ack: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr)
  );

endmodule

/* logic/id_stage.sv */
// decode happens at accept; stalls on busy rs1, rs2 and also rd, so a busy bit has one owner
`timescale 1ns/1ps
`include "core_config.svh"

module id_stage
  import riscv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_fetched_req,
  input  logic [`XLEN-1:0] i_if_pc,
  input  logic [31:0]      i_if_inst,
  input  logic             i_decoded_ack,
  input  logic [`XLEN-1:0] i_rs1_data,
  input  logic [`XLEN-1:0] i_rs2_data,
  input  logic [4:0]       i_wb_rd,
  input  logic             i_wb_rd_wen,
  output logic             o_fetched_ack,
  output logic [4:0]       o_rs1,
  output logic [4:0]       o_rs2,
  output logic             o_decoded_req,
  output logic [`XLEN-1:0] o_id_pc,
  output logic [31:0]      o_id_inst,
  output logic [`XLEN-1:0] o_id_op1,
  output logic [`XLEN-1:0] o_id_op2,
  output logic [`XLEN-1:0] o_id_imm,
  output alu_op_e          o_id_alu_op,
  output res_sel_e         o_id_res_sel,
  output logic             o_id_is_branch,
  output logic             o_id_branch_ne,
  output logic             o_id_is_jal,
  output logic [4:0]       o_id_rd,
  output logic             o_id_rd_wen
);

  inst_u             inst;
  logic [`XLEN-1:0]  imm;
  logic [`XLEN-1:0]  op1;
  logic [`XLEN-1:0]  op2;
  alu_op_e           alu_op;
  res_sel_e          res_sel;
  logic              use_rs1;
  logic              use_rs2;
  logic              rd_wen;
  logic              is_branch;
  logic              is_jal;
  logic              hazard;
  logic              issue;
  logic [`NREGS-1:0] busy;
  logic [`NREGS-1:0] busy_eff;
  logic [`NREGS-1:0] clr_mask;
  logic [`NREGS-1:0] set_mask;

  assign inst  = i_if_inst;
  assign o_rs1 = inst.i.rs1;
  assign o_rs2 = inst.r.rs2;

  always_comb begin
    imm       = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
    op1       = i_rs1_data;
    op2       = i_rs2_data;
    alu_op    = ALU_ADD;
    res_sel   = RES_ALU;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    rd_wen    = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    case (inst.r.opcode)
      OPC_OP, OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        use_rs2 = (inst.r.opcode == OPC_OP);
        rd_wen  = 1'b1;
        if (!use_rs2) begin
          op2 = imm;
        end
        case (inst.r.funct3)
          F3_ADD_SUB: alu_op = (use_rs2 && inst.r.funct7[5]) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL_SRA: alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    alu_op = ALU_ADD;
        endcase
      end
      OPC_LUI, OPC_AUIPC: begin
        imm     = {{(`XLEN-32){inst.r.funct7[6]}}, inst.r.funct7, inst.r.rs2, inst.r.rs1,
                   inst.r.funct3, 12'b0};
        rd_wen  = 1'b1;
        op1     = i_if_pc;
        op2     = imm;
        res_sel = (inst.r.opcode == OPC_LUI) ? RES_IMM : RES_ALU;
      end
      OPC_JAL: begin
        imm     = {{(`XLEN-21){inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rs1, inst.r.funct3,
                   inst.r.rs2[0], inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};
        rd_wen  = 1'b1;
        res_sel = RES_PC4;
        is_jal  = 1'b1;
      end
      OPC_BRANCH: begin
        imm       = {{(`XLEN-13){inst.r.funct7[6]}}, inst.r.funct7[6], inst.r.rd[0],
                     inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
        is_branch = 1'b1;
        // other compares never take, fetch resumes at pc+4
        if (inst.r.funct3 == F3_BEQ || inst.r.funct3 == F3_BNE) begin
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end else begin
          op1 = '0;
          op2 = `XLEN'd1;
        end
      end
      default: ;
    endcase
  end

  // a write in flight this cycle frees its register now, regfile bypasses the data
  assign clr_mask = i_wb_rd_wen ? (`NREGS'(1) << i_wb_rd) : '0;
  assign busy_eff = busy & ~clr_mask;
  assign hazard   = (use_rs1 && busy_eff[inst.i.rs1]) || (use_rs2 && busy_eff[inst.r.rs2]) ||
                    (rd_wen && busy_eff[inst.r.rd]);

  assign o_fetched_ack = (!o_decoded_req || i_decoded_ack) && !hazard;
  assign issue         = i_fetched_req && o_fetched_ack;
  assign set_mask      = (issue && rd_wen && inst.r.rd != 5'd0) ? (`NREGS'(1) << inst.r.rd) : '0;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy          <= '0;
      o_decoded_req <= 1'b0;
    end else begin
      busy <= busy_eff | set_mask;
      if (issue) begin
        o_decoded_req <= 1'b1;
      end else if (i_decoded_ack) begin
        o_decoded_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      o_id_pc        <= i_if_pc;
      o_id_inst      <= i_if_inst;
      o_id_op1       <= op1;
      o_id_op2       <= op2;
      o_id_imm       <= imm;
      o_id_alu_op    <= alu_op;
      o_id_res_sel   <= res_sel;
      o_id_is_branch <= is_branch;
      o_id_branch_ne <= (inst.r.funct3 == F3_BNE);
      o_id_is_jal    <= is_jal;
      o_id_rd        <= inst.r.rd;
      o_id_rd_wen    <= rd_wen;
    end
  end

  // wb frees only a register that decode marked busy
  a_clear_only_busy: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    i_wb_rd_wen |-> busy[i_wb_rd]
  );

endmodule

/* logic/exe_stage.sv */
// single-cycle ALU; JAL and every branch send one redirect, taken or not
`timescale 1ns/1ps
`include "core_config.svh"

module exe_stage
  import core_pipe_pkg::*;
(
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_decoded_req,
  input  logic [`XLEN-1:0] i_id_pc,
  input  logic [31:0]      i_id_inst,
  input  logic [`XLEN-1:0] i_id_op1,
  input  logic [`XLEN-1:0] i_id_op2,
  input  logic [`XLEN-1:0] i_id_imm,
  input  alu_op_e          i_id_alu_op,
  input  res_sel_e         i_id_res_sel,
  input  logic             i_id_is_branch,
  input  logic             i_id_branch_ne,
  input  logic             i_id_is_jal,
  input  logic [4:0]       i_id_rd,
  input  logic             i_id_rd_wen,
  input  logic             i_executed_ack,
  output logic             o_decoded_ack,
  output logic             o_executed_req,
  output logic [`XLEN-1:0] o_ex_pc,
  output logic [31:0]      o_ex_inst,
  output logic [4:0]       o_ex_rd,
  output logic             o_ex_rd_wen,
  output logic [`XLEN-1:0] o_ex_wdata,
  output logic             o_redirect,
  output logic [`XLEN-1:0] o_redirect_pc
);

  localparam int SHW = $clog2(`XLEN);

  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] res;
  logic [`XLEN-1:0] pc_plus4;
  logic [SHW-1:0]   shamt;
  logic             taken;
  logic             accept;
  logic             ctrl_q;

  assign o_decoded_ack = !o_executed_req || i_executed_ack;
  assign accept        = i_decoded_req && o_decoded_ack;
  assign shamt         = i_id_op2[SHW-1:0];
  assign pc_plus4      = i_id_pc + `XLEN'd4;

  always_comb begin
    case (i_id_alu_op)
      ALU_ADD:  alu_res = i_id_op1 + i_id_op2;
      ALU_SUB:  alu_res = i_id_op1 - i_id_op2;
      ALU_SLL:  alu_res = i_id_op1 << shamt;
      ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(i_id_op1) < $signed(i_id_op2)};
      ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, i_id_op1 < i_id_op2};
      ALU_XOR:  alu_res = i_id_op1 ^ i_id_op2;
      ALU_SRL:  alu_res = i_id_op1 >> shamt;
      ALU_SRA:  alu_res = $signed(i_id_op1) >>> shamt;
      ALU_OR:   alu_res = i_id_op1 | i_id_op2;
      ALU_AND:  alu_res = i_id_op1 & i_id_op2;
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (i_id_res_sel)
      RES_PC4: res = pc_plus4;
      RES_IMM: res = i_id_imm;
      default: res = alu_res;
    endcase
  end

  // BEQ and BNE only
  assign taken = i_id_is_jal ||
                 (i_id_is_branch && ((i_id_op1 == i_id_op2) != i_id_branch_ne));

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_executed_req <= 1'b0;
    end else if (accept) begin
      o_executed_req <= 1'b1;
    end else if (i_executed_ack) begin
      o_executed_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_ex_pc       <= i_id_pc;
      o_ex_inst     <= i_id_inst;
      o_ex_rd       <= i_id_rd;
      o_ex_rd_wen   <= i_id_rd_wen;
      o_ex_wdata    <= res;
      ctrl_q        <= i_id_is_branch || i_id_is_jal;
      o_redirect_pc <= taken ? (i_id_pc + i_id_imm) : pc_plus4;
    end
  end

  // pulse in the ex->wb transfer cycle
  assign o_redirect = o_executed_req && i_executed_ack && ctrl_q;

endmodule

/* logic/wb_stage.sv */
// never back-pressures; commit data is valid only while o_cmt_valid is high
`timescale 1ns/1ps
`include "core_config.svh"

module wb_stage (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_executed_req,
  input  logic [`XLEN-1:0] i_ex_pc,
  input  logic [31:0]      i_ex_inst,
  input  logic [4:0]       i_ex_rd,
  input  logic             i_ex_rd_wen,
  input  logic [`XLEN-1:0] i_ex_wdata,
  output logic             o_executed_ack,
  output logic [4:0]       o_rd,
  output logic             o_rd_wen,
  output logic [`XLEN-1:0] o_rd_wdata,
  output logic             o_cmt_valid,
  output logic [`XLEN-1:0] o_cmt_pc,
  output logic [31:0]      o_cmt_inst,
  output logic             o_cmt_rd_wen,
  output logic [4:0]       o_cmt_rd,
  output logic [`XLEN-1:0] o_cmt_wdata
);

  logic             valid;
  logic [`XLEN-1:0] pc_q;
  logic [31:0]      inst_q;
  logic [4:0]       rd_q;
  logic             rd_wen_q;
  logic [`XLEN-1:0] wdata_q;

  // retires in one cycle, so always ready
  assign o_executed_ack = 1'b1;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid <= 1'b0;
    end else begin
      valid <= i_executed_req;
    end
  end

  always_ff @(posedge clk) begin
    if (i_executed_req) begin
      pc_q     <= i_ex_pc;
      inst_q   <= i_ex_inst;
      rd_q     <= i_ex_rd;
      rd_wen_q <= i_ex_rd_wen;
      wdata_q  <= i_ex_wdata;
    end
  end

  // x0 is never written
  assign o_rd_wen   = valid && rd_wen_q && (rd_q != 5'd0);
  assign o_rd       = rd_q;
  assign o_rd_wdata = wdata_q;

  assign o_cmt_valid  = valid;
  assign o_cmt_pc     = pc_q;
  assign o_cmt_inst   = inst_q;
  assign o_cmt_rd_wen = o_rd_wen;
  assign o_cmt_rd     = rd_q;
  assign o_cmt_wdata  = wdata_q;

endmodule

/* logic/regfile.sv */
// x0 hardwired to zero; a write in the same cycle is visible on both read ports
`timescale 1ns/1ps
`include "core_config.svh"

module regfile (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic [4:0]       i_rs1,
  input  logic [4:0]       i_rs2,
  input  logic [4:0]       i_rd,
  input  logic             i_rd_wen,
  input  logic [`XLEN-1:0] i_rd_data,
  output logic [`XLEN-1:0] o_rs1_data,
  output logic [`XLEN-1:0] o_rs2_data
);

  logic [`XLEN-1:0] regs [`NREGS];

  function automatic logic [`XLEN-1:0] read_port(input logic [4:0] idx);
    if (idx == 5'd0) begin
      return '0;
    end else if (i_rd_wen && i_rd == idx) begin
      return i_rd_data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < `NREGS; k++) begin
        regs[k] <= '0;
      end
    end else if (i_rd_wen && i_rd != 5'd0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  always_comb begin
    o_rs1_data = read_port(i_rs1);
    o_rs2_data = read_port(i_rs2);
  end

endmodule

/* logic/cpu.sv */
// rv64i subset core with a read-only wishbone classic fetch port; no data memory access
`timescale 1ns/1ps
`include "core_config.svh"

module cpu
  import core_pipe_pkg::*;
(
  input  logic             clk,
  input  logic             i_rst_n,
  output logic             o_wb_cyc,
  output logic             o_wb_stb,
  output logic [`XLEN-1:0] o_wb_adr,
  input  logic [31:0]      i_wb_dat,
  input  logic             i_wb_ack,
  output logic             o_cmt_valid,
  output logic [`XLEN-1:0] o_cmt_pc,
  output logic [31:0]      o_cmt_inst,
  output logic             o_cmt_rd_wen,
  output logic [4:0]       o_cmt_rd,
  output logic [`XLEN-1:0] o_cmt_wdata
);

  // stage handshakes
  logic fetched_req;
  logic fetched_ack;
  logic decoded_req;
  logic decoded_ack;
  logic executed_req;
  logic executed_ack;

  logic [`XLEN-1:0] if_pc;
  logic [31:0]      if_inst;
  logic             redirect;
  logic [`XLEN-1:0] redirect_pc;

  logic [4:0]       rs1;
  logic [4:0]       rs2;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;

  logic [`XLEN-1:0] id_pc;
  logic [31:0]      id_inst;
  logic [`XLEN-1:0] id_op1;
  logic [`XLEN-1:0] id_op2;
  logic [`XLEN-1:0] id_imm;
  alu_op_e          id_alu_op;
  res_sel_e         id_res_sel;
  logic             id_is_branch;
  logic             id_branch_ne;
  logic             id_is_jal;
  logic [4:0]       id_rd;
  logic             id_rd_wen;

  logic [`XLEN-1:0] ex_pc;
  logic [31:0]      ex_inst;
  logic [4:0]       ex_rd;
  logic             ex_rd_wen;
  logic [`XLEN-1:0] ex_wdata;

  // register file write port, also frees busy bits
  logic [4:0]       wb_rd;
  logic             wb_rd_wen;
  logic [`XLEN-1:0] wb_rd_wdata;

  if_stage u_if_stage (
    .clk, .i_rst_n,
    .i_fetched_ack(fetched_ack), .o_fetched_req(fetched_req),
    .o_wb_cyc, .o_wb_stb, .o_wb_adr, .i_wb_dat, .i_wb_ack,
    .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .o_if_pc(if_pc), .o_if_inst(if_inst)
  );

  id_stage u_id_stage (
    .clk, .i_rst_n,
    .i_fetched_req(fetched_req), .o_fetched_ack(fetched_ack),
    .i_if_pc(if_pc), .i_if_inst(if_inst),
    .i_decoded_ack(decoded_ack), .o_decoded_req(decoded_req),
    .o_rs1(rs1), .o_rs2(rs2), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .i_wb_rd(wb_rd), .i_wb_rd_wen(wb_rd_wen),
    .o_id_pc(id_pc), .o_id_inst(id_inst), .o_id_op1(id_op1), .o_id_op2(id_op2),
    .o_id_imm(id_imm), .o_id_alu_op(id_alu_op), .o_id_res_sel(id_res_sel),
    .o_id_is_branch(id_is_branch), .o_id_branch_ne(id_branch_ne), .o_id_is_jal(id_is_jal),
    .o_id_rd(id_rd), .o_id_rd_wen(id_rd_wen)
  );

  exe_stage u_exe_stage (
    .clk, .i_rst_n,
    .i_decoded_req(decoded_req), .o_decoded_ack(decoded_ack),
    .i_id_pc(id_pc), .i_id_inst(id_inst), .i_id_op1(id_op1), .i_id_op2(id_op2),
    .i_id_imm(id_imm), .i_id_alu_op(id_alu_op), .i_id_res_sel(id_res_sel),
    .i_id_is_branch(id_is_branch), .i_id_branch_ne(id_branch_ne), .i_id_is_jal(id_is_jal),
    .i_id_rd(id_rd), .i_id_rd_wen(id_rd_wen),
    .i_executed_ack(executed_ack), .o_executed_req(executed_req),
    .o_ex_pc(ex_pc), .o_ex_inst(ex_inst), .o_ex_rd(ex_rd), .o_ex_rd_wen(ex_rd_wen),
    .o_ex_wdata(ex_wdata), .o_redirect(redirect), .o_redirect_pc(redirect_pc)
  );

  wb_stage u_wb_stage (
    .clk, .i_rst_n,
    .i_executed_req(executed_req), .o_executed_ack(executed_ack),
    .i_ex_pc(ex_pc), .i_ex_inst(ex_inst), .i_ex_rd(ex_rd), .i_ex_rd_wen(ex_rd_wen),
    .i_ex_wdata(ex_wdata),
    .o_rd(wb_rd), .o_rd_wen(wb_rd_wen), .o_rd_wdata(wb_rd_wdata),
    .o_cmt_valid, .o_cmt_pc, .o_cmt_inst, .o_cmt_rd_wen, .o_cmt_rd, .o_cmt_wdata
  );

  regfile u_regfile (
    .clk, .i_rst_n,
    .i_rs1(rs1), .i_rs2(rs2), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_rd(wb_rd), .i_rd_wen(wb_rd_wen), .i_rd_data(wb_rd_wdata)
  );

endmodule

/* verif/cpu_checker.sv */
// in-order rv64i subset model; program image must sit at RESET_PC and end in jal x0,0
`timescale 1ns/1ps
`include "core_config.svh"

module cpu_checker
  import riscv_isa_pkg::*;
#(
  parameter int MEM_WORDS = 256,
  parameter int PROG_LEN  = 200
) (
  input  logic             clk,
  input  logic             i_rst_n,
  input  logic             i_stop_run,
  input  logic [31:0]      i_prog [MEM_WORDS],
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic [`XLEN-1:0] i_wb_adr,
  input  logic             i_cmt_valid,
  input  logic [`XLEN-1:0] i_cmt_pc,
  input  logic [31:0]      i_cmt_inst,
  input  logic             i_cmt_rd_wen,
  input  logic [4:0]       i_cmt_rd,
  input  logic [`XLEN-1:0] i_cmt_wdata,
  output logic             o_done,
  output int               o_tests_run,
  output int               o_tests_failed,
  output int               o_errors,
  output int               o_commits
);

  localparam int               AW      = $clog2(MEM_WORDS);
  localparam logic [`XLEN-1:0] STOP_PC = PROG_LEN * 4;

  logic [`XLEN-1:0] xreg [32];
  logic [`XLEN-1:0] pc;
  logic             reset_done;
  logic             fetch_seen;
  int               reset_errs;
  int               fetch_errs;
  int               stream_errs;

  initial begin
    o_done         = 1'b0;
    o_tests_run    = 0;
    o_tests_failed = 0;
    o_errors       = 0;
    o_commits      = 0;
    reset_done     = 1'b0;
    fetch_seen     = 1'b0;
    reset_errs     = 0;
    fetch_errs     = 0;
    stream_errs    = 0;
    pc             = `RESET_PC;
    for (int k = 0; k < 32; k++) begin
      xreg[k] = '0;
    end
  end

  task automatic finish_test(input string name, input int errs);
    o_tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      o_tests_failed++;
      $display("test %s: failed with %0d errors", name, errs);
    end
  endtask

  task automatic report_problem(input string msg);
    o_errors++;
    $display("ERROR: %s", msg);
  endtask

  task automatic compare_field(input string name, input logic [`XLEN-1:0] exp,
                               input logic [`XLEN-1:0] act, inout int errs);
    if (exp !== act) begin
      errs++;
      o_errors++;
      $display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  function automatic logic [`XLEN-1:0] alu_result(input logic [2:0] f3, input logic sub,
                                                  input logic arith, input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
    case (f3)
      F3_ADD_SUB: return sub ? a - b : a + b;
      F3_SLL:     return a << b[5:0];
      F3_SLT:     return {63'b0, $signed(a) < $signed(b)};
      F3_SLTU:    return {63'b0, a < b};
      F3_XOR:     return a ^ b;
      F3_OR:      return a | b;
      F3_AND:     return a & b;
      default: begin
        // arithmetic shift kept apart from the logical one
        if (arith) begin
          return $signed(a) >>> b[5:0];
        end
        return a >> b[5:0];
      end
    endcase
  endfunction

  task automatic check_commit;
    logic [31:0]      inst;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] res;
    logic [`XLEN-1:0] next_pc;
    logic [4:0]       rd;
    logic             wen;
    inst    = i_prog[pc[AW+1:2]];
    a       = xreg[inst[19:15]];
    b       = xreg[inst[24:20]];
    rd      = inst[11:7];
    imm_i   = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    imm_u   = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    wen     = 1'b1;
    res     = '0;
    next_pc = pc + 4;
    case (inst[6:0])
      OPC_OP:     res = alu_result(inst[14:12], inst[30], inst[30], a, b);
      OPC_OP_IMM: res = alu_result(inst[14:12], 1'b0, inst[30], a, imm_i);
      OPC_LUI:    res = imm_u;
      OPC_AUIPC:  res = pc + imm_u;
      OPC_JAL: begin
        res     = pc + 4;
        next_pc = pc + {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21],
                        1'b0};
      end
      OPC_BRANCH: begin
        wen = 1'b0;
        if (inst[14:13] == 2'b00 && (inst[12] ? a != b : a == b)) begin
          next_pc = pc + {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8],
                          1'b0};
        end
      end
      default: wen = 1'b0;
    endcase
    if (rd == 5'd0) begin
      wen = 1'b0;
    end
    o_commits++;
    compare_field("o_cmt_pc", pc, i_cmt_pc, stream_errs);
    compare_field("o_cmt_inst", inst, i_cmt_inst, stream_errs);
    compare_field("o_cmt_rd_wen", wen, i_cmt_rd_wen, stream_errs);
    compare_field("o_cmt_rd", rd, i_cmt_rd, stream_errs);
    if (wen) begin
      compare_field("o_cmt_wdata", res, i_cmt_wdata, stream_errs);
      xreg[rd] = res;
    end
    if (pc == STOP_PC && inst == 32'h0000_006f) begin
      o_done = 1'b1;
      finish_test("commit_stream", stream_errs);
    end
    pc = next_pc;
  endtask

  always @(negedge clk) begin
    if (!reset_done) begin
      if (i_wb_cyc !== 1'b0 || i_wb_stb !== 1'b0 || i_cmt_valid !== 1'b0) begin
        reset_errs++;
        report_problem($sformatf("outputs active in reset at %0t: cyc %b stb %b cmt_valid %b",
                                 $time, i_wb_cyc, i_wb_stb, i_cmt_valid));
      end
      if (i_rst_n) begin
        reset_done = 1'b1;
        finish_test("reset_state", reset_errs);
      end
    end else if (i_rst_n) begin
      if (!fetch_seen && i_wb_cyc) begin
        fetch_seen = 1'b1;
        compare_field("o_wb_adr", `RESET_PC, i_wb_adr, fetch_errs);
        compare_field("o_wb_stb", 1'b1, i_wb_stb, fetch_errs);
        finish_test("first_fetch", fetch_errs);
      end
      // a runaway stream would only repeat the first errors
      if (i_cmt_valid && !o_done && stream_errs < 50) begin
        check_commit();
      end
    end
  end

  always @(posedge i_stop_run) begin
    if (!fetch_seen) begin
      report_problem("no bus cycle was started after reset");
      finish_test("first_fetch", 1);
    end
    if (!o_done) begin
      report_problem($sformatf("the stop loop at pc %0h never retired, %0d instructions committed",
                               STOP_PC, o_commits));
      finish_test("commit_stream", stream_errs + 1);
    end
    finish_test("stop_loop", o_done ? 0 : 1);
  end

endmodule

/* verif/tb_cpu.sv */
// random program of 200 legal instructions at RESET_PC, memory acks after 0 to 3 wait cycles
`timescale 1ns/1ps
`include "core_config.svh"

module tb_cpu
  import riscv_isa_pkg::*;
();

  localparam int PROG_LEN     = 200;
  localparam int MEM_WORDS    = 256;
  localparam int RESET_CYCLES = 16;
  // 3 ack wait plus 6 through the pipe per instruction
  localparam int TIMEOUT_CYCLES = PROG_LEN * (3 + 6) + RESET_CYCLES;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic [`XLEN-1:0] wb_adr;
  logic [31:0]      wb_dat;
  logic             wb_ack;
  logic             cmt_valid;
  logic [`XLEN-1:0] cmt_pc;
  logic [31:0]      cmt_inst;
  logic             cmt_rd_wen;
  logic [4:0]       cmt_rd;
  logic [`XLEN-1:0] cmt_wdata;
  logic             stop_run;
  logic             chk_done;
  logic             timed_out;
  int               tests_run;
  int               tests_failed;
  int               errors;
  int               commits;
  int               cycles = 0;
  int               ack_wait;
  integer           seed;
  logic [31:0]      prog_mem [MEM_WORDS];

  cpu dut (
    .clk, .i_rst_n(rst_n),
    .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr),
    .i_wb_dat(wb_dat), .i_wb_ack(wb_ack),
    .o_cmt_valid(cmt_valid), .o_cmt_pc(cmt_pc), .o_cmt_inst(cmt_inst),
    .o_cmt_rd_wen(cmt_rd_wen), .o_cmt_rd(cmt_rd), .o_cmt_wdata(cmt_wdata)
  );

  cpu_checker #(.MEM_WORDS(MEM_WORDS), .PROG_LEN(PROG_LEN)) chk (
    .clk, .i_rst_n(rst_n), .i_stop_run(stop_run), .i_prog(prog_mem),
    .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_adr(wb_adr),
    .i_cmt_valid(cmt_valid), .i_cmt_pc(cmt_pc), .i_cmt_inst(cmt_inst),
    .i_cmt_rd_wen(cmt_rd_wen), .i_cmt_rd(cmt_rd), .i_cmt_wdata(cmt_wdata),
    .o_done(chk_done), .o_tests_run(tests_run), .o_tests_failed(tests_failed),
    .o_errors(errors), .o_commits(commits)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  task automatic build_program;
    int          kind;
    int          lim;
    int          skip;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [19:0] upper;
    logic [20:0] joff;
    logic [12:0] boff;
    // unused words decode as an unsupported opcode
    for (int k = 0; k < MEM_WORDS; k++) begin
      prog_mem[k] = {k[24:0], 7'h0b};
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      kind  = $random(seed) & 7;
      f3    = $random(seed);
      // x0..x7 only, so dependencies are frequent
      rd    = $random(seed) & 7;
      rs1   = $random(seed) & 7;
      rs2   = $random(seed) & 7;
      imm   = $random(seed);
      upper = $random(seed);
      lim   = (PROG_LEN - i < 4) ? PROG_LEN - i : 4;
      skip  = 1 + (($random(seed) & 255) % lim);
      joff  = skip * 4;
      boff  = skip * 4;
      case (kind)
        0, 1: begin
          prog_mem[i] = {((f3 == 3'b000 || f3 == 3'b101) && imm[0]) ? 7'h20 : 7'h00,
                         rs2, rs1, f3, rd, OPC_OP};
        end
        2, 3: begin
          if (f3 == 3'b001) begin
            imm[11:6] = 6'b0;
          end else if (f3 == 3'b101) begin
            imm[11:6] = {1'b0, imm[10], 4'b0};
          end
          prog_mem[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
        end
        4: prog_mem[i] = {upper, rd, OPC_LUI};
        5: prog_mem[i] = {upper, rd, OPC_AUIPC};
        6: prog_mem[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
        default: begin
          prog_mem[i] = {boff[12], boff[10:5], rs2, rs1, 2'b00, f3[0], boff[4:1], boff[11],
                         OPC_BRANCH};
        end
      endcase
    end
    // jal x0,0 stop loop
    prog_mem[PROG_LEN] = {25'd0, OPC_JAL};
  endtask

  // wishbone classic slave, one ack per request
  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      wb_ack   = 1'b0;
      ack_wait = -1;
    end else if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (ack_wait < 0) begin
        ack_wait = $random(seed) & 3;
      end
      if (ack_wait == 0) begin
        wb_dat   = prog_mem[wb_adr[9:2]];
        wb_ack   = 1'b1;
        ack_wait = -1;
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    wb_dat    = 32'h0;
    wb_ack    = 1'b0;
    stop_run  = 1'b0;
    timed_out = 1'b0;
    ack_wait  = -1;
    seed      = 32'hfd47_44ae;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    while (!chk_done && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    if (!chk_done) begin
      timed_out = 1'b1;
      $display("timeout: the stop loop did not retire within %0d cycles", TIMEOUT_CYCLES);
    end
    stop_run = 1'b1;
    #1;
    $display("tests run %0d, failed %0d, errors %0d, commits %0d, cycles %0d",
             tests_run, tests_failed, errors, commits, cycles);
    if (!timed_out && tests_failed == 0 && errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* core_lite.f */
+incdir+logic
logic/riscv_isa_pkg.sv
logic/core_pipe_pkg.sv
logic/if_stage.sv
logic/id_stage.sv
logic/exe_stage.sv
logic/wb_stage.sv
logic/regfile.sv
logic/cpu.sv
verif/cpu_checker.sv
verif/tb_cpu.sv
